// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = arp_tb
FILELIST  = all.f
SIMFLAGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: all.f
src/arp_pkg.sv
src/arp_ram_dp.sv
src/arp_table.sv
src/arp_rx_parser.sv
src/arp_tx_serializer.sv
src/arp_top.sv
testbench/arp_sva.sv
testbench/arp_checker.sv
testbench/arp_tb.sv

// File: src/arp_pkg.sv
package arp_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_addr_t;

  // Field order matches the byte order on the wire
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_addr_t   src_mac;
    ipv4_t       src_ipv4;
    mac_addr_t   dst_mac;
    ipv4_t       dst_ipv4;
  } arp_hdr_t;

  localparam int ARP_TBL_ADDR_W    = 2;
  localparam int ARP_TBL_SIZE      = 2 ** ARP_TBL_ADDR_W;
  localparam int ARP_ENTRY_W       = $bits(ipv4_t) + $bits(mac_addr_t);  // IPv4 above the MAC
  localparam int ARP_TIMEOUT_TICKS = 200;
  localparam int ARP_TMO_W         = $clog2(ARP_TIMEOUT_TICKS);
  localparam int ARP_HDR_BYTES     = 28;
  localparam int ARP_BYTE_CNT_W    = $clog2(ARP_HDR_BYTES);

  localparam logic [15:0] ARP_HTYPE_ETH  = 16'd1;
  localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  ARP_HLEN_ETH   = 8'd6;
  localparam logic [7:0]  ARP_PLEN_IPV4  = 8'd4;
  localparam logic [15:0] ARP_OPER_REQ   = 16'd1;
  localparam logic [15:0] ARP_OPER_REPLY = 16'd2;
  localparam mac_addr_t   MAC_BROADCAST  = 48'hffff_ffff_ffff;

endpackage

// File: src/arp_ram_dp.sv
`timescale 1ns/10ps

module arp_ram_dp #(
  parameter int ADDR_W = 2,
  parameter int DATA_W = 80
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] addr_a,
  input  logic [ADDR_W-1:0] addr_b,
  input  logic              we_a,
  input  logic [DATA_W-1:0] d_a,
  output logic [DATA_W-1:0] q_a,
  output logic [DATA_W-1:0] q_b
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // Port A reads old data during a write
  always_ff @(posedge clk) begin
    if (we_a) begin
      mem[addr_a] <= d_a;
    end
    q_a <= mem[addr_a];
  end

  // Port B is read only
  always_ff @(posedge clk) begin
    q_b <= mem[addr_b];
  end

endmodule

// File: src/arp_rx_parser.sv
`timescale 1ns/10ps

module arp_rx_parser (
  input  logic               clk,
  input  logic               rst,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  logic [7:0]         rx_data,
  input  logic               rx_valid,
  input  logic               rx_sof,
  output logic               ent_val,
  output arp_pkg::ipv4_t     ent_ipv4,
  output arp_pkg::mac_addr_t ent_mac
);

  import arp_pkg::*;

  logic [ARP_BYTE_CNT_W-1:0]      byte_cnt;  // Zero outside a packet
  logic [ARP_BYTE_CNT_W-1:0]      byte_idx;
  logic                           take_byte;
  logic                           last_byte;
  logic [(ARP_HDR_BYTES-1)*8-1:0] hdr_sr;    // First 27 bytes
  arp_hdr_t                       hdr_nxt;
  logic                           hdr_ok;

  assign byte_idx  = rx_sof ? '0 : byte_cnt;
  assign take_byte = rx_valid && (rx_sof || byte_cnt != '0);
  assign last_byte = take_byte && (byte_idx == ARP_BYTE_CNT_W'(ARP_HDR_BYTES - 1));

  // Full header with the byte on the bus appended
  assign hdr_nxt = {hdr_sr, rx_data};

  assign hdr_ok = (hdr_nxt.hw_type == ARP_HTYPE_ETH) &&
                  (hdr_nxt.proto == ARP_PTYPE_IPV4) &&
                  (hdr_nxt.hlen == ARP_HLEN_ETH) &&
                  (hdr_nxt.plen == ARP_PLEN_IPV4) &&
                  (hdr_nxt.oper == ARP_OPER_REQ || hdr_nxt.oper == ARP_OPER_REPLY) &&
                  (hdr_nxt.dst_ipv4 == dev_ipv4);

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt <= '0;
      ent_val  <= 1'b0;
    end else begin
      ent_val <= 1'b0;
      if (last_byte) begin
        byte_cnt <= '0;
        ent_val  <= hdr_ok;  // Bad packets just vanish
      end else if (take_byte) begin
        byte_cnt <= byte_idx + ARP_BYTE_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_byte) begin
      hdr_sr <= hdr_nxt[ARP_HDR_BYTES*8-9:0];
    end
    if (last_byte) begin
      ent_ipv4 <= hdr_nxt.src_ipv4;
      ent_mac  <= hdr_nxt.src_mac;
    end
  end

endmodule

// File: src/arp_table.sv
`timescale 1ns/10ps

module arp_table (
  input  logic                                clk,
  input  logic                                rst,
  input  arp_pkg::mac_addr_t                  dev_mac,
  input  arp_pkg::ipv4_t                      dev_ipv4,
  input  logic                                ent_val,
  input  arp_pkg::ipv4_t                      ent_ipv4,
  input  arp_pkg::mac_addr_t                  ent_mac,
  input  logic                                tbl_req,
  input  arp_pkg::ipv4_t                      tbl_ipv4,
  output logic                                tbl_val,
  output logic                                tbl_err,
  output arp_pkg::mac_addr_t                  tbl_mac,
  output arp_pkg::arp_hdr_t                   hdr_tx,
  output logic                                send_req,
  input  logic                                tx_busy,
  output logic [arp_pkg::ARP_TBL_ADDR_W-1:0]  addr_a,
  output logic                                we_a,
  output logic [arp_pkg::ARP_ENTRY_W-1:0]     d_a,
  input  logic [arp_pkg::ARP_ENTRY_W-1:0]     q_a,
  output logic [arp_pkg::ARP_TBL_ADDR_W-1:0]  addr_b,
  input  logic [arp_pkg::ARP_ENTRY_W-1:0]     q_b
);

  import arp_pkg::*;

  typedef enum logic [1:0] {W_IDLE, W_SCAN, W_UPD, W_ADD} w_state_t;
  typedef enum logic [1:0] {R_IDLE, R_SCAN, R_SEND, R_WAIT} r_state_t;

  w_state_t                  w_state;
  r_state_t                  r_state;

  logic [ARP_TBL_SIZE-1:0]   ent_vld;     // One flag per slot
  logic [ARP_TBL_ADDR_W-1:0] w_ptr;       // Next slot for a new entry
  logic [ARP_TBL_ADDR_W:0]   w_cnt;
  logic [ARP_TBL_ADDR_W-1:0] w_prev;      // Slot whose data sits on q_a
  ipv4_t                     cur_ipv4;
  mac_addr_t                 cur_mac;
  ipv4_t                     q_a_ipv4;
  logic                      w_hit;

  logic [ARP_TBL_ADDR_W:0]   r_cnt;
  logic [ARP_TBL_ADDR_W-1:0] r_prev;      // Slot whose data sits on q_b
  ipv4_t                     req_ipv4;
  ipv4_t                     q_b_ipv4;
  mac_addr_t                 q_b_mac;
  logic                      r_hit;
  logic [ARP_TMO_W-1:0]      tmo_cnt;

  assign d_a      = {cur_ipv4, cur_mac};
  assign q_a_ipv4 = q_a[ARP_ENTRY_W-1:$bits(mac_addr_t)];
  assign {q_b_ipv4, q_b_mac} = q_b;

  // First scan cycle has no read data yet
  assign w_hit = (w_cnt != '0) && ent_vld[w_prev] && (q_a_ipv4 == cur_ipv4);
  assign r_hit = (r_cnt != '0) && ent_vld[r_prev] && (q_b_ipv4 == req_ipv4);

  // Write path on port A
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state <= W_IDLE;
      w_ptr   <= '0;
      w_cnt   <= '0;
      ent_vld <= '0;
      addr_a  <= '0;
      we_a    <= 1'b0;
    end else begin
      case (w_state)
        W_IDLE: begin
          we_a <= 1'b0;
          if (ent_val) begin
            cur_ipv4 <= ent_ipv4;
            cur_mac  <= ent_mac;
            addr_a   <= '0;
            w_cnt    <= '0;
            w_state  <= W_SCAN;
          end
        end
        W_SCAN: begin
          w_cnt  <= w_cnt + (ARP_TBL_ADDR_W + 1)'(1);
          addr_a <= addr_a + ARP_TBL_ADDR_W'(1);
          w_prev <= addr_a;
          if (w_hit) begin
            addr_a  <= w_prev;  // Rewrite the matching slot
            we_a    <= 1'b1;
            w_state <= W_UPD;
          end else if (w_cnt[ARP_TBL_ADDR_W]) begin
            addr_a  <= w_ptr;
            we_a    <= 1'b1;
            w_state <= W_ADD;
          end
        end
        W_UPD: begin
          we_a    <= 1'b0;
          w_state <= W_IDLE;
        end
        W_ADD: begin
          we_a           <= 1'b0;
          ent_vld[w_ptr] <= 1'b1;
          w_ptr          <= w_ptr + ARP_TBL_ADDR_W'(1);
          w_state        <= W_IDLE;
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  // Lookup path on port B
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state  <= R_IDLE;
      r_cnt    <= '0;
      addr_b   <= '0;
      tbl_val  <= 1'b0;
      tbl_err  <= 1'b0;
      send_req <= 1'b0;
      tmo_cnt  <= '0;
    end else begin
      case (r_state)
        R_IDLE: begin
          tbl_val <= 1'b0;
          tbl_err <= 1'b0;
          if (tbl_req) begin
            req_ipv4 <= tbl_ipv4;
            addr_b   <= '0;
            r_cnt    <= '0;
            r_state  <= R_SCAN;
          end
        end
        R_SCAN: begin
          r_cnt  <= r_cnt + (ARP_TBL_ADDR_W + 1)'(1);
          addr_b <= addr_b + ARP_TBL_ADDR_W'(1);
          r_prev <= addr_b;
          if (r_hit) begin
            tbl_mac <= q_b_mac;
            tbl_val <= 1'b1;
            r_state <= R_IDLE;
          end else if (r_cnt[ARP_TBL_ADDR_W]) begin
            // Not in the table so ask the network
            hdr_tx.hw_type  <= ARP_HTYPE_ETH;
            hdr_tx.proto    <= ARP_PTYPE_IPV4;
            hdr_tx.hlen     <= ARP_HLEN_ETH;
            hdr_tx.plen     <= ARP_PLEN_IPV4;
            hdr_tx.oper     <= ARP_OPER_REQ;
            hdr_tx.src_mac  <= dev_mac;
            hdr_tx.src_ipv4 <= dev_ipv4;
            hdr_tx.dst_mac  <= MAC_BROADCAST;
            hdr_tx.dst_ipv4 <= req_ipv4;
            r_state         <= R_SEND;
          end
        end
        R_SEND: begin
          if (!tx_busy) begin
            send_req <= 1'b1;
            tmo_cnt  <= '0;
            r_state  <= R_WAIT;
          end
        end
        R_WAIT: begin
          send_req <= 1'b0;
          tmo_cnt  <= tmo_cnt + ARP_TMO_W'(1);
          if (ent_val && ent_ipv4 == req_ipv4) begin
            tbl_mac <= ent_mac;  // Answer straight from the reply
            tbl_val <= 1'b1;
            r_state <= R_IDLE;
          end else if (tmo_cnt == ARP_TMO_W'(ARP_TIMEOUT_TICKS - 1)) begin
            tbl_err <= 1'b1;
            r_state <= R_IDLE;
          end
        end
        default: r_state <= R_IDLE;
      endcase
    end
  end

endmodule

// File: src/arp_top.sv
`timescale 1ns/10ps

module arp_top (
  input  logic               clk,
  input  logic               rst,
  input  arp_pkg::mac_addr_t dev_mac,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  logic [7:0]         rx_data,
  input  logic               rx_valid,
  input  logic               rx_sof,
  input  logic               tbl_req,
  input  arp_pkg::ipv4_t     tbl_ipv4,
  output logic               tbl_val,
  output arp_pkg::mac_addr_t tbl_mac,
  output logic               tbl_err,
  output logic [7:0]         tx_data,
  output logic               tx_valid,
  output logic               tx_sof,
  output logic               tx_last
);

  import arp_pkg::*;

  logic                      ent_val;
  ipv4_t                     ent_ipv4;
  mac_addr_t                 ent_mac;
  arp_hdr_t                  hdr_tx;
  logic                      send_req;
  logic                      tx_busy;
  logic [ARP_TBL_ADDR_W-1:0] addr_a;
  logic [ARP_TBL_ADDR_W-1:0] addr_b;
  logic                      we_a;
  logic [ARP_ENTRY_W-1:0]    d_a;
  logic [ARP_ENTRY_W-1:0]    q_a;
  logic [ARP_ENTRY_W-1:0]    q_b;

  arp_rx_parser u_parser (
    .clk      (clk),
    .rst      (rst),
    .dev_ipv4 (dev_ipv4),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_sof   (rx_sof),
    .ent_val  (ent_val),
    .ent_ipv4 (ent_ipv4),
    .ent_mac  (ent_mac)
  );

  arp_table u_table (
    .clk      (clk),
    .rst      (rst),
    .dev_mac  (dev_mac),
    .dev_ipv4 (dev_ipv4),
    .ent_val  (ent_val),
    .ent_ipv4 (ent_ipv4),
    .ent_mac  (ent_mac),
    .tbl_req  (tbl_req),
    .tbl_ipv4 (tbl_ipv4),
    .tbl_val  (tbl_val),
    .tbl_err  (tbl_err),
    .tbl_mac  (tbl_mac),
    .hdr_tx   (hdr_tx),
    .send_req (send_req),
    .tx_busy  (tx_busy),
    .addr_a   (addr_a),
    .we_a     (we_a),
    .d_a      (d_a),
    .q_a      (q_a),
    .addr_b   (addr_b),
    .q_b      (q_b)
  );

  arp_ram_dp #(
    .ADDR_W (ARP_TBL_ADDR_W),
    .DATA_W (ARP_ENTRY_W)
  ) u_ram (
    .clk    (clk),
    .addr_a (addr_a),
    .addr_b (addr_b),
    .we_a   (we_a),
    .d_a    (d_a),
    .q_a    (q_a),
    .q_b    (q_b)
  );

  arp_tx_serializer u_tx (
    .clk      (clk),
    .rst      (rst),
    .hdr_tx   (hdr_tx),
    .send_req (send_req),
    .tx_busy  (tx_busy),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_sof   (tx_sof),
    .tx_last  (tx_last)
  );

endmodule

// File: src/arp_tx_serializer.sv
`timescale 1ns/10ps

module arp_tx_serializer (
  input  logic              clk,
  input  logic              rst,
  input  arp_pkg::arp_hdr_t hdr_tx,
  input  logic              send_req,
  output logic              tx_busy,
  output logic [7:0]        tx_data,
  output logic              tx_valid,
  output logic              tx_sof,
  output logic              tx_last
);

  import arp_pkg::*;

  logic [ARP_HDR_BYTES*8-1:0] tx_sr;
  logic [ARP_BYTE_CNT_W-1:0]  byte_cnt;
  logic                       at_last;

  assign at_last = (byte_cnt == ARP_BYTE_CNT_W'(ARP_HDR_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_busy  <= 1'b0;
      byte_cnt <= '0;
    end else if (send_req) begin
      tx_busy  <= 1'b1;
      byte_cnt <= '0;
    end else if (tx_busy) begin
      byte_cnt <= byte_cnt + ARP_BYTE_CNT_W'(1);
      if (at_last) begin
        tx_busy <= 1'b0;
      end
    end
  end

  // Header leaves MSB first
  always_ff @(posedge clk) begin
    if (send_req) begin
      tx_sr <= hdr_tx;
    end else if (tx_busy) begin
      tx_sr <= {tx_sr[ARP_HDR_BYTES*8-9:0], 8'h00};
    end
  end

  assign tx_data  = tx_sr[ARP_HDR_BYTES*8-1 -: 8];
  assign tx_valid = tx_busy;
  assign tx_sof   = tx_busy && (byte_cnt == '0);
  assign tx_last  = tx_busy && at_last;

endmodule

// File: testbench/arp_checker.sv
`timescale 1ns/10ps

module arp_checker (
  input  logic               clk,
  input  logic               rst,
  input  arp_pkg::mac_addr_t dev_mac,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  logic               tbl_req,
  input  arp_pkg::ipv4_t     tbl_ipv4,
  input  logic               tbl_val,
  input  logic               tbl_err,
  input  arp_pkg::mac_addr_t tbl_mac,
  input  logic [7:0]         tx_data,
  input  logic               tx_valid,
  input  logic               tx_sof,
  input  logic               tx_last,
  input  logic [1:0]         exp_kind,
  input  arp_pkg::mac_addr_t exp_mac,
  output int                 err_cnt,
  output int                 chk_cnt
);

  import arp_pkg::*;

  localparam logic [1:0] KIND_HIT     = 2'd1;  // Same encoding as the testbench rows
  localparam logic [1:0] KIND_REPLY   = 2'd2;
  localparam logic [1:0] KIND_TIMEOUT = 2'd3;

  int                         errs = 0;
  int                         checks = 0;
  logic                       pending = 1'b0;
  logic [1:0]                 kind;
  ipv4_t                      req_ipv4;
  mac_addr_t                  mac_q;
  logic [ARP_HDR_BYTES*8-1:0] req_hdr;  // Request the DUT should send
  int                         tx_idx;
  int                         tx_cyc;   // Cycles since the first request byte

  assign err_cnt = errs;
  assign chk_cnt = checks;

  task automatic compare_value(input string sig, input logic [47:0] got, input logic [47:0] want);
    checks++;
    if (got !== want) begin
      $display("FAILED %s: got %0h, expected %0h", sig, got, want);
      errs++;
    end
  endtask

  task automatic check_tx_byte();
    logic [7:0] want;
    if (!pending || kind == KIND_HIT) begin
      $display("Error: request byte sent although no miss is pending");
      errs++;
    end else if (tx_idx >= ARP_HDR_BYTES) begin
      $display("Error: request for %h is longer than %0d bytes", req_ipv4, ARP_HDR_BYTES);
      errs++;
    end else begin
      want = req_hdr[(ARP_HDR_BYTES - 1 - tx_idx) * 8 +: 8];
      compare_value($sformatf("tx_data[%0d]", tx_idx), 48'(tx_data), 48'(want));
      compare_value($sformatf("tx_sof[%0d]", tx_idx), 48'(tx_sof), 48'(tx_idx == 0));
      compare_value($sformatf("tx_last[%0d]", tx_idx), 48'(tx_last),
                    48'(tx_idx == ARP_HDR_BYTES - 1));
    end
    if (tx_idx == 0) begin
      tx_cyc = 0;
    end
    tx_idx++;
  endtask

  task automatic close_lookup();
    int want_bytes;
    want_bytes = (kind == KIND_HIT) ? 0 : ARP_HDR_BYTES;
    if (!pending) begin
      $display("Error: lookup result seen with no lookup pending");
      errs++;
    end else begin
      if (kind == KIND_TIMEOUT) begin
        if (tbl_val) begin
          $display("Error: lookup of %h answered although no reply was sent", req_ipv4);
          errs++;
        end else if (tx_idx != 0 && tx_cyc != ARP_TIMEOUT_TICKS - 1) begin
          // First request byte trails send_req by one cycle
          $display("Error: tbl_err for %h came %0d cycles after the request was sent, %0d expected",
                   req_ipv4, tx_cyc + 1, ARP_TIMEOUT_TICKS);
          errs++;
        end
      end else if (!tbl_val) begin
        $display("Error: lookup of %h ended in tbl_err instead of an answer", req_ipv4);
        errs++;
      end else begin
        compare_value("tbl_mac", tbl_mac, mac_q);
      end
      if (tx_idx != want_bytes) begin
        $display("Error: %0d request bytes sent for %h, %0d expected",
                 tx_idx, req_ipv4, want_bytes);
        errs++;
      end
    end
    pending = 1'b0;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      tx_cyc++;
      if (tbl_req) begin
        pending  = 1'b1;
        kind     = exp_kind;
        req_ipv4 = tbl_ipv4;
        mac_q    = exp_mac;
        tx_idx   = 0;
        req_hdr  = {ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN_ETH, ARP_PLEN_IPV4,
                    ARP_OPER_REQ, dev_mac, dev_ipv4, MAC_BROADCAST, tbl_ipv4};
      end
      if (tx_valid) begin
        check_tx_byte();
      end
      if (tbl_val || tbl_err) begin
        close_lookup();
      end
    end
  end

endmodule

// File: testbench/arp_sva.sv
`timescale 1ns/10ps

module arp_sva (
  input logic clk,
  input logic rst,
  input logic tbl_val,
  input logic tbl_err,
  input logic send_req,
  input logic tx_busy
);

  int fail_cnt = 0;  // Read by the testbench at the end

  a_val_err: assert property (@(posedge clk) disable iff (rst) !(tbl_val && tbl_err))
    else begin
      fail_cnt++;
      $error("tbl_val and tbl_err are high in the same cycle");
    end

  a_send_pulse: assert property (@(posedge clk) disable iff (rst) send_req |=> !send_req)
    else begin
      fail_cnt++;
      $error("send_req stayed high for more than one cycle");
    end

  a_send_idle: assert property (@(posedge clk) disable iff (rst) $rose(send_req) |-> !tx_busy)
    else begin
      fail_cnt++;
      $error("send_req rose while the serializer was busy");
    end

endmodule

bind arp_table arp_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .tbl_val  (tbl_val),
  .tbl_err  (tbl_err),
  .send_req (send_req),
  .tx_busy  (tx_busy)
);

// File: testbench/arp_tb.sv
`timescale 1ns/10ps

module arp_tb;

  import arp_pkg::*;

  typedef enum logic {OP_INJECT, OP_LOOKUP} op_t;
  typedef enum logic [1:0] {PKT_GOOD, PKT_BAD_HLEN, PKT_BAD_TARGET} pkt_t;
  typedef enum logic [1:0] {EXP_NONE, EXP_HIT, EXP_REPLY, EXP_TIMEOUT} exp_t;

  typedef struct packed {
    op_t       op;
    ipv4_t     ipv4;
    mac_addr_t mac;      // Sender MAC or the MAC a hit returns
    pkt_t      pkt;
    exp_t      outcome;
  } row_t;

  localparam int NUM_ROWS = 23;
  localparam int HIT_WAIT = ARP_TBL_SIZE + 3;
  localparam int TX_WAIT  = 2 * ARP_HDR_BYTES;
  localparam int TMO_WAIT = ARP_TIMEOUT_TICKS + 2 * ARP_HDR_BYTES;

  logic       clk = 1'b0;
  logic       rst;
  mac_addr_t  dev_mac;
  ipv4_t      dev_ipv4;
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_sof;
  logic       tbl_req;
  ipv4_t      tbl_ipv4;
  logic       tbl_val;
  mac_addr_t  tbl_mac;
  logic       tbl_err;
  logic [7:0] tx_data;
  logic       tx_valid;
  logic       tx_sof;
  logic       tx_last;
  logic [1:0] exp_kind;
  mac_addr_t  exp_mac;
  int         err_cnt;
  int         chk_cnt;
  int         timeouts = 0;
  integer     seed = 32'he32f8692;
  row_t       rows [NUM_ROWS];

  initial forever #50 clk = ~clk;

  arp_top uut (
    .clk (clk), .rst (rst), .dev_mac (dev_mac), .dev_ipv4 (dev_ipv4),
    .rx_data (rx_data), .rx_valid (rx_valid), .rx_sof (rx_sof),
    .tbl_req (tbl_req), .tbl_ipv4 (tbl_ipv4), .tbl_val (tbl_val),
    .tbl_mac (tbl_mac), .tbl_err (tbl_err), .tx_data (tx_data),
    .tx_valid (tx_valid), .tx_sof (tx_sof), .tx_last (tx_last)
  );

  arp_checker u_chk (
    .clk (clk), .rst (rst), .dev_mac (dev_mac), .dev_ipv4 (dev_ipv4),
    .tbl_req (tbl_req), .tbl_ipv4 (tbl_ipv4), .tbl_val (tbl_val),
    .tbl_err (tbl_err), .tbl_mac (tbl_mac), .tx_data (tx_data),
    .tx_valid (tx_valid), .tx_sof (tx_sof), .tx_last (tx_last),
    .exp_kind (exp_kind), .exp_mac (exp_mac), .err_cnt (err_cnt), .chk_cnt (chk_cnt)
  );

  task automatic load_rows();
    rows[0]  = '{OP_INJECT, 32'hc0a8_0010, 48'h0a00_0000_0010, PKT_GOOD, EXP_NONE};
    rows[1]  = '{OP_INJECT, 32'hc0a8_0011, 48'h0a00_0000_0011, PKT_GOOD, EXP_NONE};
    rows[2]  = '{OP_INJECT, 32'hc0a8_0012, 48'h0a00_0000_0012, PKT_GOOD, EXP_NONE};
    rows[3]  = '{OP_LOOKUP, 32'hc0a8_0010, 48'h0a00_0000_0010, PKT_GOOD, EXP_HIT};
    rows[4]  = '{OP_LOOKUP, 32'hc0a8_0011, 48'h0a00_0000_0011, PKT_GOOD, EXP_HIT};
    rows[5]  = '{OP_LOOKUP, 32'hc0a8_0012, 48'h0a00_0000_0012, PKT_GOOD, EXP_HIT};
    rows[6]  = '{OP_INJECT, 32'hc0a8_0010, 48'h0a00_0000_00a0, PKT_GOOD, EXP_NONE};  // Update
    rows[7]  = '{OP_LOOKUP, 32'hc0a8_0010, 48'h0a00_0000_00a0, PKT_GOOD, EXP_HIT};
    rows[8]  = '{OP_INJECT, 32'hc0a8_0013, 48'h0a00_0000_0013, PKT_GOOD, EXP_NONE};
    rows[9]  = '{OP_INJECT, 32'hc0a8_0014, 48'h0a00_0000_0014, PKT_GOOD, EXP_NONE};  // Evicts .10
    rows[10] = '{OP_LOOKUP, 32'hc0a8_0011, 48'h0a00_0000_0011, PKT_GOOD, EXP_HIT};
    rows[11] = '{OP_LOOKUP, 32'hc0a8_0013, 48'h0a00_0000_0013, PKT_GOOD, EXP_HIT};
    rows[12] = '{OP_LOOKUP, 32'hc0a8_0010, 48'h0, PKT_GOOD, EXP_TIMEOUT};
    rows[13] = '{OP_INJECT, 32'hc0a8_0015, 48'h0a00_0000_0015, PKT_GOOD, EXP_NONE};
    rows[14] = '{OP_INJECT, 32'hc0a8_0016, 48'h0a00_0000_0016, PKT_GOOD, EXP_NONE};
    rows[15] = '{OP_LOOKUP, 32'hc0a8_0016, 48'h0a00_0000_0016, PKT_GOOD, EXP_HIT};
    rows[16] = '{OP_LOOKUP, 32'hc0a8_0012, 48'h0, PKT_GOOD, EXP_REPLY};
    rows[17] = '{OP_LOOKUP, 32'hc0a8_0014, 48'h0a00_0000_0014, PKT_GOOD, EXP_HIT};
    rows[18] = '{OP_INJECT, 32'hc0a8_0020, 48'h0a00_0000_0020, PKT_BAD_HLEN, EXP_NONE};
    rows[19] = '{OP_INJECT, 32'hc0a8_0021, 48'h0a00_0000_0021, PKT_BAD_TARGET, EXP_NONE};
    rows[20] = '{OP_LOOKUP, 32'hc0a8_0020, 48'h0, PKT_GOOD, EXP_TIMEOUT};
    rows[21] = '{OP_LOOKUP, 32'hc0a8_0021, 48'h0, PKT_GOOD, EXP_TIMEOUT};
    rows[22] = '{OP_LOOKUP, 32'hc0a8_0015, 48'h0a00_0000_0015, PKT_GOOD, EXP_HIT};
  endtask

  function automatic logic [223:0] build_pkt(input logic [15:0] oper, input mac_addr_t smac,
                                              input ipv4_t sip, input mac_addr_t dmac,
                                              input ipv4_t dip, input logic [7:0] hlen);
    build_pkt = {16'h0001, 16'h0800, hlen, 8'h04, oper, smac, sip, dmac, dip};
  endfunction

  task automatic send_pkt(input logic [223:0] pkt);
    int i;
    for (i = 0; i < 28; i++) begin
      rx_valid = 1'b1;
      rx_sof   = (i == 0);
      rx_data  = pkt[(27 - i) * 8 +: 8];
      @(negedge clk);
    end
    rx_valid = 1'b0;
    rx_sof   = 1'b0;
    rx_data  = 8'h00;
  endtask

  task automatic inject_row(input row_t r);
    logic [7:0] hlen;
    ipv4_t      dip;
    hlen = (r.pkt == PKT_BAD_HLEN) ? 8'h05 : 8'h06;
    dip  = (r.pkt == PKT_BAD_TARGET) ? 32'hc0a8_0063 : dev_ipv4;  // Someone else's address
    send_pkt(build_pkt(16'h0001, r.mac, r.ipv4, 48'h0, dip, hlen));
  endtask

  task automatic wait_tx_last(input ipv4_t ip);
    int n;
    n = 0;
    while (!tx_last && n < TX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!tx_last) begin
      $display("Error: request for %h did not finish within %0d cycles", ip, TX_WAIT);
      timeouts++;
    end
  endtask

  task automatic wait_result(input int limit, input ipv4_t ip);
    int n;
    n = 0;
    while (!(tbl_val || tbl_err) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!(tbl_val || tbl_err)) begin
      $display("Error: no lookup result for %h within %0d cycles", ip, limit);
      timeouts++;
    end
  endtask

  task automatic lookup_row(input row_t r);
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    exp_kind = r.outcome;
    exp_mac  = r.mac;
    if (r.outcome == EXP_REPLY) begin
      rnd_hi  = $random(seed);
      rnd_lo  = $random(seed);
      exp_mac = {rnd_hi[15:0], rnd_lo};
    end
    tbl_ipv4 = r.ipv4;
    tbl_req  = 1'b1;
    @(negedge clk);
    tbl_req = 1'b0;
    if (r.outcome == EXP_REPLY) begin
      wait_tx_last(r.ipv4);
      send_pkt(build_pkt(16'h0002, exp_mac, r.ipv4, dev_mac, dev_ipv4, 8'h06));
      wait_result(HIT_WAIT, r.ipv4);
    end else if (r.outcome == EXP_TIMEOUT) begin
      wait_result(TMO_WAIT, r.ipv4);
    end else begin
      wait_result(HIT_WAIT, r.ipv4);
    end
  endtask

  initial begin
    int i;
    load_rows();
    rst      = 1'b1;
    dev_mac  = 48'h0200_0000_0001;
    dev_ipv4 = 32'hc0a8_0001;
    rx_data  = 8'h00;
    rx_valid = 1'b0;
    rx_sof   = 1'b0;
    tbl_req  = 1'b0;
    tbl_ipv4 = 32'h0;
    exp_kind = EXP_NONE;
    exp_mac  = 48'h0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    for (i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].op == OP_INJECT) begin
        inject_row(rows[i]);
      end else begin
        lookup_row(rows[i]);
      end
      repeat (8) @(negedge clk);  // Table write lands within 7 cycles of ent_val
    end
    repeat (4) @(negedge clk);
    $display("Result: %0d checks, %0d mismatches, %0d assertion failures, %0d timeouts",
             chk_cnt, err_cnt, uut.u_table.u_sva.fail_cnt, timeouts);
    if (err_cnt == 0 && uut.u_table.u_sva.fail_cnt == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
